/* Makefile */
# Verilator build and run of the acquisition front end testbench

TOP = acq_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -Mdir obj_dir -f sim.f

# pass only when the testbench prints its pass line
run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^Test passed$$'

clean:
	rm -rf obj_dir

/* acq_control/acq_control.sv */
`timescale 1ns/1ns
// acquisition sequencer
// scans the analog multiplexer, starts each conversion and hands the
// result to the serial link as two bytes, one per half of the second mux
// three machines cooperate through single-cycle request and done pulses
module acq_control
	import acq_pkg::*;
(
	input  logic     clock,
	input  logic     arst_n,
	input  logic     eoc,
	input  logic     byte_done,
	output logic     mux_en,
	output logic     soc,
	output logic     load_dato,
	output logic     add_mpx2,
	output logic     load,
	output logic     send,
	output channel_t channel
);

	scan_state_t scan_state;
	pair_state_t pair_state;
	link_state_t link_state;

	// settling clocks elapsed since mux_en rose
	settle_t settle_cnt;

	// scan to pair handoff and its return
	logic pair_start;
	logic pair_done;

	// pair to link request and its return
	logic link_req;
	logic link_done;

	// scan machine
	// also owns the channel counter, which moves once per conversion
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			scan_state <= scan_mux;
			settle_cnt <= '0;
			mux_en     <= 1'b0;
			soc        <= 1'b0;
			load_dato  <= 1'b0;
			pair_start <= 1'b0;
			channel    <= '0;
		end else begin
			pair_start <= 1'b0;
			case (scan_state)
				scan_mux: begin
					// enable the analog mux on the current channel
					mux_en     <= 1'b1;
					settle_cnt <= '0;
					scan_state <= scan_settle;
				end
				scan_settle: begin
					if (settle_cnt == settle_t'(settle_cycles - 1)) begin
						soc        <= 1'b1;
						scan_state <= scan_conv;
					end else begin
						settle_cnt <= settle_cnt + 1'b1;
					end
				end
				scan_conv: begin
					// converter holds us off for as long as eoc stays low
					if (eoc) begin
						soc        <= 1'b0;
						mux_en     <= 1'b0;
						load_dato  <= 1'b1;
						scan_state <= scan_load;
					end
				end
				scan_load: begin
					load_dato <= 1'b0;
					// step to the next input, wrapping after the last one
					if (channel == channel_t'(num_channels - 1)) begin
						channel <= '0;
					end else begin
						channel <= channel + 1'b1;
					end
					pair_start <= 1'b1;
					scan_state <= scan_pair;
				end
				scan_pair: begin
					// next scan only once both bytes have left the link
					if (pair_done) begin
						scan_state <= scan_mux;
					end
				end
				default: begin
					scan_state <= scan_mux;
				end
			endcase
		end
	end

	// pair machine
	// add_mpx2 only moves while the link machine is idle
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pair_state <= pair_idle;
			add_mpx2   <= 1'b0;
			link_req   <= 1'b0;
			pair_done  <= 1'b0;
		end else begin
			link_req  <= 1'b0;
			pair_done <= 1'b0;
			case (pair_state)
				pair_idle: begin
					if (pair_start) begin
						// lower half first
						link_req   <= 1'b1;
						pair_state <= pair_first;
					end
				end
				pair_first: begin
					if (link_done) begin
						add_mpx2   <= 1'b1;
						link_req   <= 1'b1;
						pair_state <= pair_second;
					end
				end
				pair_second: begin
					if (link_done) begin
						add_mpx2   <= 1'b0;
						pair_done  <= 1'b1;
						pair_state <= pair_idle;
					end
				end
				default: begin
					pair_state <= pair_idle;
				end
			endcase
		end
	end

	// link machine
	// load then send on consecutive cycles, done on buffer completion
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			link_state <= link_idle;
			load       <= 1'b0;
			send       <= 1'b0;
			link_done  <= 1'b0;
		end else begin
			link_done <= 1'b0;
			case (link_state)
				link_idle: begin
					if (link_req) begin
						load       <= 1'b1;
						link_state <= link_load;
					end
				end
				link_load: begin
					load       <= 1'b0;
					send       <= 1'b1;
					link_state <= link_send;
				end
				link_send: begin
					send       <= 1'b0;
					link_state <= link_wait;
				end
				link_wait: begin
					// byte_done also covers a refused byte
					if (byte_done) begin
						link_done  <= 1'b1;
						link_state <= link_idle;
					end
				end
				default: begin
					link_state <= link_idle;
				end
			endcase
		end
	end

endmodule

/* bench/acq_checker.sv */
`timescale 1ns/1ns
// protocol checks on the acquisition front end strobes
// bound into the top level to reach the internal link nets
module acq_checker (
	input logic clock,
	input logic arst_n,
	input logic error,
	input logic byte_done,
	input logic tx_end,
	input logic load,
	input logic send,
	input logic mux_en,
	input logic load_dato,
	input logic soc
);

	// a frame that went out always closes with error clear
	assert property (@(posedge clock) disable iff (!arst_n)
		(byte_done && $past(tx_end)) |-> !error)
		else $error("error high at completion of a sent frame");

	// link strobes come on separate cycles
	assert property (@(posedge clock) disable iff (!arst_n) !(load && send))
		else $error("load and send high together");

	assert property (@(posedge clock) disable iff (!arst_n) !(mux_en && load_dato))
		else $error("mux_en and load_dato high together");

	assert property (@(posedge clock) disable iff (!arst_n) load_dato |-> !soc)
		else $error("soc still high during load_dato");

endmodule

bind acq_top acq_checker acq_checker_i (
	.clock     (clock),
	.arst_n    (arst_n),
	.error     (error),
	.byte_done (byte_done),
	.tx_end    (tx_end),
	.load      (load),
	.send      (send),
	.mux_en    (mux_en),
	.load_dato (load_dato),
	.soc       (soc)
);

/* bench/acq_tb.sv */
`timescale 1ns/1ns
// testbench for the acquisition front end
// models the converter and the second multiplexer, receives the serial
// frames and runs directed scans, a long conversion and a dsr refusal
module acq_tb
	import acq_pkg::*;
();

	logic     clock;
	logic     arst_n;
	logic     eoc;
	sample_t  data_in;
	logic     dsr;
	logic     mux_en;
	logic     soc;
	logic     load_dato;
	logic     add_mpx2;
	channel_t channel;
	logic     error;
	logic     data_out;

	// converter result per channel and per half of the second mux
	sample_t  byte_table [num_channels][2];
	integer   seed;
	int       conv_delay = 0;
	int       conv_cnt;
	// channel whose result sits in the converter latch
	channel_t conv_ch;
	// channel the next conversion should report
	channel_t exp_ch;

	acq_top acq_top_i (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// converter and mux model updated just after each rising edge
	initial begin
		seed = 2;
		for (int c = 0; c < num_channels; c++) begin
			byte_table[c[2:0]][0] = sample_t'($random(seed));
			byte_table[c[2:0]][1] = sample_t'($random(seed));
		end
		eoc = 1'b0;
		data_in = '0;
		conv_cnt = 0;
		conv_ch = '0;
		forever begin
			@(posedge clock);
			#1;
			if (load_dato) begin
				// result latched for the channel just converted
				conv_ch = channel;
				eoc = 1'b0;
				conv_cnt = 0;
			end else if (soc && !eoc) begin
				if (conv_cnt >= conv_delay) eoc = 1'b1;
				else conv_cnt++;
			end
			data_in = byte_table[conv_ch][add_mpx2];
		end
	end

	task automatic fail_now();
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s at %0t ns", what, $time);
		fail_now();
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s, expected %b, got %b", $time, what, expected, actual);
			fail_now();
		end
	endtask

	task automatic check_sample(input sample_t actual, input sample_t expected, input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
			fail_now();
		end
	endtask

	task automatic check_channel(input channel_t actual, input channel_t expected,
			input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s, expected %0d, got %0d", $time, what, expected, actual);
			fail_now();
		end
	endtask

	task automatic wait_mux_en();
		int waited;
		waited = 0;
		while (mux_en !== 1'b1) begin
			if (waited == 100) report_timeout("mux_en");
			@(negedge clock);
			waited++;
		end
	endtask

	// samples each bit in its middle, and checks the level holds for the whole bit
	task automatic receive_frame(output sample_t value, input logic half);
		int   waited;
		logic level;
		logic mid;
		waited = 0;
		value = '0;
		// line stays high until the start bit
		while (data_out !== 1'b0) begin
			if (waited == 60) report_timeout("start bit");
			@(negedge clock);
			waited++;
		end
		check_bit(add_mpx2, half, "add_mpx2 during frame");
		for (int b = 0; b < 10; b++) begin
			level = data_out;
			mid = data_out;
			for (int c = 1; c < bit_period; c++) begin
				@(negedge clock);
				check_bit(data_out, level, "line level within one bit");
				if (c == bit_period / 2) mid = data_out;
			end
			if (b == 0) check_bit(mid, 1'b0, "start bit");
			else if (b == 9) check_bit(mid, 1'b1, "stop bit");
			else value = {value[6:0], mid};
			if (b < 9) @(negedge clock);
		end
	endtask

	// one full scan step with settle, convert, latch and two frames
	task automatic do_conversion(input int delay);
		sample_t got;
		int      waited;
		conv_delay = delay;
		wait_mux_en();
		check_channel(channel, exp_ch, "channel at mux_en");
		waited = 0;
		while (soc !== 1'b1) begin
			if (waited == 10) report_timeout("soc");
			@(negedge clock);
			waited++;
		end
		check_bit(waited == settle_cycles, 1'b1, "soc delay after mux_en");
		waited = 0;
		// soc is held until eoc as converter back-pressure
		while (load_dato !== 1'b1) begin
			if (waited == delay + 20) report_timeout("load_dato");
			check_bit(soc, 1'b1, "soc held during conversion");
			check_bit(mux_en, 1'b1, "mux_en held during conversion");
			@(negedge clock);
			waited++;
		end
		check_bit(waited >= delay, 1'b1, "soc held for the converter delay");
		check_bit(soc, 1'b0, "soc low with load_dato");
		check_bit(mux_en, 1'b0, "mux_en low with load_dato");
		@(negedge clock);
		check_bit(load_dato, 1'b0, "load_dato single pulse");
		check_channel(channel, exp_ch + 1'b1, "channel after load_dato");
		receive_frame(got, 1'b0);
		check_sample(got, byte_table[exp_ch][0], "first byte of pair");
		receive_frame(got, 1'b1);
		check_sample(got, byte_table[exp_ch][1], "second byte of pair");
		check_bit(error, 1'b0, "error after clean pair");
		exp_ch = exp_ch + 1'b1;
	endtask

	// eight clocks of reset, then mux_en on the first edge after release
	task automatic reset_and_release();
		repeat (4) @(posedge clock);
		@(negedge clock);
		check_bit(mux_en, 1'b0, "mux_en in reset");
		check_bit(soc, 1'b0, "soc in reset");
		check_bit(load_dato, 1'b0, "load_dato in reset");
		check_bit(add_mpx2, 1'b0, "add_mpx2 in reset");
		check_bit(error, 1'b0, "error in reset");
		check_bit(data_out, 1'b1, "data_out in reset");
		check_channel(channel, '0, "channel in reset");
		repeat (4) @(posedge clock);
		#1;
		arst_n = 1'b1;
		@(negedge clock);
		check_bit(mux_en, 1'b0, "mux_en before first edge after reset");
		@(negedge clock);
		check_bit(mux_en, 1'b1, "mux_en first cycle after reset");
	endtask

	// nine conversions over channels 0 to 7 and a wrap to 0
	task automatic scan_all_channels();
		for (int k = 0; k < 9; k++) begin
			do_conversion(k % 4);
		end
	endtask

	task automatic long_conversion();
		do_conversion(400);
	endtask

	// lower byte refused with dsr low and upper byte sent normally
	task automatic refuse_on_dsr();
		sample_t got;
		int      waited;
		conv_delay = 2;
		wait_mux_en();
		check_channel(channel, exp_ch, "channel at mux_en");
		@(posedge clock);
		#1;
		dsr = 1'b0;
		waited = 0;
		while (error !== 1'b1) begin
			if (waited == 200) report_timeout("error after refused send");
			check_bit(data_out, 1'b1, "line idle while dsr low");
			@(negedge clock);
			waited++;
		end
		check_bit(add_mpx2, 1'b0, "refused byte is lower half");
		@(posedge clock);
		#1;
		dsr = 1'b1;
		waited = 0;
		// refused byte leaves the line idle until the upper half starts
		while (add_mpx2 !== 1'b1) begin
			if (waited == 20) report_timeout("add_mpx2 after refusal");
			@(negedge clock);
			check_bit(data_out, 1'b1, "no start bit for refused byte");
			check_bit(error, 1'b1, "error held until next accepted send");
			waited++;
		end
		receive_frame(got, 1'b1);
		check_sample(got, byte_table[exp_ch][1], "byte after refusal");
		check_bit(error, 1'b0, "error cleared by accepted send");
		exp_ch = exp_ch + 1'b1;
	endtask

	initial begin
		arst_n = 1'b0;
		dsr = 1'b1;
		exp_ch = '0;
		reset_and_release();
		scan_all_channels();
		long_conversion();
		refuse_on_dsr();
		// scan carries on after the refusal
		do_conversion(1);
		$display("Test passed");
		$finish;
	end

endmodule

/* common/acq_pkg.sv */
// acquisition front end shared definitions
// widths, serial timing and state encodings for the logger datapath
package acq_pkg;

	// one converted byte from the external converter
	typedef logic [7:0] sample_t;

	// analog channel select on the first multiplexer
	typedef logic [2:0] channel_t;

	// counts clocks inside one serial bit
	typedef logic [6:0] bit_timer_t;

	// counts settling clocks before a conversion start
	typedef logic [1:0] settle_t;

	// channel counter wraps after the last input
	localparam int num_channels = 8;

	// clocks per serial bit, same threshold as the legacy logger
	localparam int bit_period = 105;

	// multiplexer settling time before soc
	localparam int settle_cycles = 2;

	// scan machine: select, settle, convert, latch, then hand off the pair
	typedef enum logic [2:0] {
		scan_mux,
		scan_settle,
		scan_conv,
		scan_load,
		scan_pair
	} scan_state_t;

	// pair machine: one link cycle per half of the second multiplexer
	typedef enum logic [1:0] {
		pair_idle,
		pair_first,
		pair_second
	} pair_state_t;

	// link machine: load strobe, send strobe, then wait for completion
	typedef enum logic [1:0] {
		link_idle,
		link_load,
		link_send,
		link_wait
	} link_state_t;

	// serializer frame position
	typedef enum logic [1:0] {
		txs_idle,
		txs_start,
		txs_data,
		txs_stop
	} tx_state_t;

endpackage

/* logic/acq_top.sv */
`timescale 1ns/1ns
// acquisition front end top level
// sequencer, transmit buffer and serializer between the converter,
// the two multiplexers and the serial line
module acq_top
	import acq_pkg::*;
(
	input  logic     clock,
	input  logic     arst_n,
	input  logic     eoc,
	input  sample_t  data_in,
	input  logic     dsr,
	output logic     mux_en,
	output logic     soc,
	output logic     load_dato,
	output logic     add_mpx2,
	output channel_t channel,
	output logic     error,
	output logic     data_out
);

	// link strobes from the sequencer
	logic load;
	logic send;

	// buffer to serializer
	logic    tx_start;
	sample_t tx_data;
	logic    tx_end;

	// end of every link cycle, sent or refused
	logic byte_done;

	acq_control acq_control_i (
		.clock     (clock),
		.arst_n    (arst_n),
		.eoc       (eoc),
		.byte_done (byte_done),
		.mux_en    (mux_en),
		.soc       (soc),
		.load_dato (load_dato),
		.add_mpx2  (add_mpx2),
		.load      (load),
		.send      (send),
		.channel   (channel)
	);

	sample_buffer sample_buffer_i (
		.clock     (clock),
		.arst_n    (arst_n),
		.load      (load),
		.send      (send),
		.dsr       (dsr),
		.tx_end    (tx_end),
		.data_in   (data_in),
		.tx_data   (tx_data),
		.tx_start  (tx_start),
		.byte_done (byte_done),
		.error     (error)
	);

	serial_tx serial_tx_i (
		.clock    (clock),
		.arst_n   (arst_n),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.data_out (data_out),
		.tx_end   (tx_end)
	);

endmodule

/* logic/sample_buffer.sv */
`timescale 1ns/1ns
// transmit holding register
// one byte deep, judges buffer state and dsr, keeps a sticky error
// and reports completion of every link cycle on byte_done
module sample_buffer
	import acq_pkg::*;
(
	input  logic    clock,
	input  logic    arst_n,
	input  logic    load,
	input  logic    send,
	input  logic    dsr,
	input  logic    tx_end,
	input  sample_t data_in,
	output sample_t tx_data,
	output logic    tx_start,
	output logic    byte_done,
	output logic    error
);

	// byte held and not yet sent or dropped
	logic full;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			full      <= 1'b0;
			error     <= 1'b0;
			tx_start  <= 1'b0;
			byte_done <= 1'b0;
		end else begin
			tx_start  <= 1'b0;
			byte_done <= 1'b0;
			// end of frame frees the buffer, completion follows next cycle
			if (tx_end) begin
				full      <= 1'b0;
				byte_done <= 1'b1;
			end
			// overrun, new byte is lost and the held one kept
			if (load) begin
				if (full) begin
					error <= 1'b1;
				end else begin
					full <= 1'b1;
				end
			end
			if (send) begin
				if (!full || !dsr) begin
					// refused: drop the byte and close the link cycle now
					error     <= 1'b1;
					full      <= 1'b0;
					byte_done <= 1'b1;
				end else begin
					error    <= 1'b0;
					tx_start <= 1'b1;
				end
			end
		end
	end

	// payload capture on an accepted load
	always_ff @(posedge clock) begin
		if (load && !full) begin
			tx_data <= data_in;
		end
	end

endmodule

/* logic/serial_tx.sv */
`timescale 1ns/1ns
// 8N1 serializer
// start bit, eight data bits MSB first and a stop bit, each held for
// bit_period clocks; line idles high between frames
module serial_tx
	import acq_pkg::*;
(
	input  logic    clock,
	input  logic    arst_n,
	input  logic    tx_start,
	input  sample_t tx_data,
	output logic    data_out,
	output logic    tx_end
);

	tx_state_t  tx_state;
	bit_timer_t bit_timer;

	// data bits already put on the line, minus one
	logic [2:0] bit_cnt;

	// outgoing byte, top bit is the next one on the line
	sample_t shift_reg;

	// last clock of the current bit
	logic bit_last;

	assign bit_last = (bit_timer == bit_timer_t'(bit_period - 1));

	// frame closes in the final cycle of the stop bit
	assign tx_end = (tx_state == txs_stop) && bit_last;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			tx_state  <= txs_idle;
			bit_timer <= '0;
			bit_cnt   <= '0;
			data_out  <= 1'b1;
		end else begin
			case (tx_state)
				txs_idle: begin
					// a start request while busy never reaches here
					if (tx_start) begin
						data_out  <= 1'b0;
						bit_timer <= '0;
						tx_state  <= txs_start;
					end
				end
				txs_start: begin
					if (bit_last) begin
						data_out  <= shift_reg[7];
						bit_timer <= '0;
						bit_cnt   <= '0;
						tx_state  <= txs_data;
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
				txs_data: begin
					if (bit_last) begin
						bit_timer <= '0;
						if (bit_cnt == 3'd7) begin
							data_out <= 1'b1;
							tx_state <= txs_stop;
						end else begin
							data_out <= shift_reg[7];
							bit_cnt  <= bit_cnt + 1'b1;
						end
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
				txs_stop: begin
					if (bit_last) begin
						bit_timer <= '0;
						tx_state  <= txs_idle;
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
				default: begin
					tx_state <= txs_idle;
				end
			endcase
		end
	end

	// shifter loads on a frame start and steps at each data bit
	always_ff @(posedge clock) begin
		if (tx_state == txs_idle && tx_start) begin
			shift_reg <= tx_data;
		end else if (bit_last && (tx_state == txs_start || tx_state == txs_data)) begin
			shift_reg <= {shift_reg[6:0], 1'b0};
		end
	end

endmodule

/* sim.f */
common/acq_pkg.sv
acq_control/acq_control.sv
logic/sample_buffer.sv
logic/serial_tx.sv
logic/acq_top.sv
bench/acq_checker.sv
bench/acq_tb.sv
